// File: rtl/cfg_if.sv
/*
 * configuration and status bundle between register block and sequencer
 */
`timescale 1ns/1ps
`include "tile_ctrl_macros.svh"

interface cfg_if;

  logic                  start;   // one-cycle pulse
  tile_ctrl_pkg::layer_e layer;
  logic [`TC_CNT_W-1:0]  tile_s;
  logic [`TC_CNT_W-1:0]  tile_e;
  logic [`TC_CNT_W-1:0]  tile_p;
  logic [`TC_CNT_W-1:0]  tile_f;
  logic                  busy;

  modport regs (output start, layer, tile_s, tile_e, tile_p, tile_f, input busy);

  modport seq (input start, layer, tile_s, tile_e, tile_p, tile_f, output busy);

endinterface

// File: rtl/cfg_regs.sv
/*
 * wishbone classic slave with layer and tile-count registers,
 * start pulse generation and status readback
 */
`timescale 1ns/1ps
`include "tile_ctrl_macros.svh"

module cfg_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [`TC_WB_AW-1:0] wb_adr_i,
  input  logic [`TC_WB_DW-1:0] wb_dat_i,
  output logic [`TC_WB_DW-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  cfg_if.regs                  cfg
);

  localparam logic [`TC_WB_AW-1:0] ADDR_CTRL   = 3'd0;
  localparam logic [`TC_WB_AW-1:0] ADDR_TILE_S = 3'd1;
  localparam logic [`TC_WB_AW-1:0] ADDR_TILE_E = 3'd2;
  localparam logic [`TC_WB_AW-1:0] ADDR_TILE_P = 3'd3;
  localparam logic [`TC_WB_AW-1:0] ADDR_TILE_F = 3'd4;
  localparam logic [`TC_WB_AW-1:0] ADDR_STATUS = 3'd5;

  logic                  ack_q;
  logic                  req;
  logic                  wr;
  logic                  start_q;
  tile_ctrl_pkg::layer_e layer_q;
  logic [`TC_CNT_W-1:0]  tile_s_q;
  logic [`TC_CNT_W-1:0]  tile_e_q;
  logic [`TC_CNT_W-1:0]  tile_p_q;
  logic [`TC_CNT_W-1:0]  tile_f_q;
  logic [`TC_WB_DW-1:0]  rdata;
  logic [`TC_WB_DW-1:0]  rdata_q;

  // new request only while no ack is out
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr  = req & wb_we_i;

  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      ADDR_CTRL:   rdata[2:1] = layer_q;  // start bit reads 0
      ADDR_TILE_S: rdata[`TC_CNT_W-1:0] = tile_s_q;
      ADDR_TILE_E: rdata[`TC_CNT_W-1:0] = tile_e_q;
      ADDR_TILE_P: rdata[`TC_CNT_W-1:0] = tile_p_q;
      ADDR_TILE_F: rdata[`TC_CNT_W-1:0] = tile_f_q;
      ADDR_STATUS: rdata[0] = cfg.busy;
      default:     rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      start_q  <= 1'b0;
      layer_q  <= tile_ctrl_pkg::Linear;
      tile_s_q <= '0;
      tile_e_q <= '0;
      tile_p_q <= '0;
      tile_f_q <= '0;
    end else begin
      ack_q   <= req;
      start_q <= wr && (wb_adr_i == ADDR_CTRL) && wb_dat_i[0];
      if (wr) begin
        case (wb_adr_i)
          ADDR_CTRL:   layer_q  <= tile_ctrl_pkg::layer_e'(wb_dat_i[2:1]);
          ADDR_TILE_S: tile_s_q <= wb_dat_i[`TC_CNT_W-1:0];
          ADDR_TILE_E: tile_e_q <= wb_dat_i[`TC_CNT_W-1:0];
          ADDR_TILE_P: tile_p_q <= wb_dat_i[`TC_CNT_W-1:0];
          ADDR_TILE_F: tile_f_q <= wb_dat_i[`TC_CNT_W-1:0];
          default: ;  // status is read-only
        endcase
      end
    end
  end

  // read data, sampled with the ack
  always_ff @(posedge clk_i) begin
    if (req) begin
      rdata_q <= rdata;
    end
  end

  assign wb_ack_o   = ack_q;
  assign wb_dat_o   = rdata_q;
  assign cfg.start  = start_q;
  assign cfg.layer  = layer_q;
  assign cfg.tile_s = tile_s_q;
  assign cfg.tile_e = tile_e_q;
  assign cfg.tile_p = tile_p_q;
  assign cfg.tile_f = tile_f_q;

endmodule

// File: rtl/flow_gate.sv
/*
 * beat acceptance, per-tile beat count and output back-pressure
 */
`timescale 1ns/1ps
`include "tile_ctrl_macros.svh"

module flow_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic active_i,
  input  logic last_inner_i,
  input  logic inp_valid_i,
  input  logic weight_valid_i,
  input  logic bias_valid_i,
  input  logic oup_valid_i,
  input  logic oup_ready_i,
  output logic inp_ready_o,
  output logic weight_ready_o,
  output logic bias_ready_o,
  output logic calc_en_o,
  output logic tile_done_o
);

  localparam int BEAT_W = $clog2(`TC_BEATS_PER_TILE);
  localparam int FLT_W  = $clog2(`TC_FIFO_DEPTH + 1);

  logic [BEAT_W-1:0] beat_q;
  logic [FLT_W-1:0]  inflight_q;
  logic              stall;
  logic              open;
  logic              inc;
  logic              dec;

  assign stall = (inflight_q >= FLT_W'(`TC_FIFO_DEPTH));  // output FIFO full
  assign open  = active_i & ~stall;

  assign inp_ready_o    = open & weight_valid_i;
  assign weight_ready_o = open & inp_valid_i;
  assign bias_ready_o   = open & weight_valid_i;
  assign calc_en_o      = open & inp_valid_i & weight_valid_i & bias_valid_i;
  assign tile_done_o    = calc_en_o && (beat_q == BEAT_W'(`TC_BEATS_PER_TILE - 1));

  // last-inner beats produce output, handshakes drain it
  assign inc = calc_en_o & last_inner_i;
  assign dec = oup_valid_i & oup_ready_i & (inflight_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_q     <= '0;
      inflight_q <= '0;
    end else begin
      if (!active_i) begin
        beat_q <= '0;
      end else if (calc_en_o) begin
        beat_q <= tile_done_o ? '0 : beat_q + BEAT_W'(1);
      end
      case ({inc, dec})
        2'b10:   inflight_q <= inflight_q + FLT_W'(1);
        2'b01:   inflight_q <= inflight_q - FLT_W'(1);
        default: inflight_q <= inflight_q;  // none or both
      endcase
    end
  end

endmodule

// File: rtl/tile_ctrl_macros.svh
/*
 * tile geometry, FIFO limit and bus widths of the tiling controller
 */
`ifndef TILE_CTRL_MACROS_SVH
`define TILE_CTRL_MACROS_SVH

// tile edge and beats per row group
`define TC_M 4
`define TC_N 2
`define TC_BEATS_PER_TILE ((`TC_M * `TC_M) / `TC_N)

// output tiles allowed in flight
`define TC_FIFO_DEPTH 4

// counters and tile-count fields
`define TC_CNT_W 8

// wishbone data width and word-address width
`define TC_WB_DW 32
`define TC_WB_AW 3

`endif

// File: rtl/tile_ctrl_pkg.sv
/*
 * layer and step encodings of the tiling controller
 */
package tile_ctrl_pkg;

  // layer type as written to CTRL[2:1]
  typedef enum logic [1:0] {
    Linear      = 2'd0,
    Feedforward = 2'd1
  } layer_e;

  // current step of the sequencer
  typedef enum logic [1:0] {
    Idle   = 2'd0,
    MatMul = 2'd1,  // linear
    F1     = 2'd2,  // feedforward, first matmul
    F2     = 2'd3   // feedforward, second matmul
  } step_e;

endpackage

// File: rtl/tile_ctrl_top.sv
/*
 * tiling controller top: register block, step sequencer, flow gate
 */
`timescale 1ns/1ps
`include "tile_ctrl_macros.svh"

module tile_ctrl_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [`TC_WB_AW-1:0] wb_adr_i,
  input  logic [`TC_WB_DW-1:0] wb_dat_i,
  output logic [`TC_WB_DW-1:0] wb_dat_o,
  output logic                 wb_ack_o,
  input  logic                 inp_valid_i,
  input  logic                 weight_valid_i,
  input  logic                 bias_valid_i,
  input  logic                 oup_valid_i,
  input  logic                 oup_ready_i,
  output logic                 inp_ready_o,
  output logic                 weight_ready_o,
  output logic                 bias_ready_o,
  output logic                 calc_en_o,
  output tile_ctrl_pkg::step_e step_o,
  output logic [`TC_CNT_W-1:0] tile_x_o,
  output logic [`TC_CNT_W-1:0] tile_y_o,
  output logic [`TC_CNT_W-1:0] inner_tile_o,
  output logic                 first_inner_tile_o,
  output logic                 last_inner_tile_o,
  output logic                 busy_o
);

  logic active;
  logic tile_done;

  cfg_if cfg_bus ();

  cfg_regs cfg_regs_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .cfg      (cfg_bus.regs)
  );

  tile_sequencer tile_sequencer_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .cfg                (cfg_bus.seq),
    .tile_done_i        (tile_done),
    .active_o           (active),
    .step_o             (step_o),
    .tile_x_o           (tile_x_o),
    .tile_y_o           (tile_y_o),
    .inner_tile_o       (inner_tile_o),
    .first_inner_tile_o (first_inner_tile_o),
    .last_inner_tile_o  (last_inner_tile_o)
  );

  flow_gate flow_gate_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .active_i       (active),
    .last_inner_i   (last_inner_tile_o),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .oup_valid_i    (oup_valid_i),
    .oup_ready_i    (oup_ready_i),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .calc_en_o      (calc_en_o),
    .tile_done_o    (tile_done)
  );

  assign busy_o = active;  // step not idle

endmodule

// File: rtl/tile_sequencer.sv
/*
 * step FSM with outer and inner tile counters
 */
`timescale 1ns/1ps
`include "tile_ctrl_macros.svh"

module tile_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  cfg_if.seq                   cfg,
  input  logic                 tile_done_i,
  output logic                 active_o,
  output tile_ctrl_pkg::step_e step_o,
  output logic [`TC_CNT_W-1:0] tile_x_o,
  output logic [`TC_CNT_W-1:0] tile_y_o,
  output logic [`TC_CNT_W-1:0] inner_tile_o,
  output logic                 first_inner_tile_o,
  output logic                 last_inner_tile_o
);

  tile_ctrl_pkg::step_e step_d, step_q;
  logic [`TC_CNT_W-1:0] inner_d, inner_q;
  logic [`TC_CNT_W-1:0] x_d, x_q;
  logic [`TC_CNT_W-1:0] y_d, y_q;
  logic [`TC_CNT_W-1:0] inner_lim;
  logic [`TC_CNT_W-1:0] x_lim;
  logic [`TC_CNT_W-1:0] inner_last;
  logic [`TC_CNT_W-1:0] x_last;
  logic [`TC_CNT_W-1:0] y_last;

  // loop limits of the current step
  always_comb begin
    case (step_q)
      tile_ctrl_pkg::F1: begin
        inner_lim = cfg.tile_e;
        x_lim     = cfg.tile_f;
      end
      tile_ctrl_pkg::F2: begin
        inner_lim = cfg.tile_f;
        x_lim     = cfg.tile_e;
      end
      default: begin  // MatMul, Idle
        inner_lim = cfg.tile_e;
        x_lim     = cfg.tile_p;
      end
    endcase
  end

  assign inner_last = inner_lim - `TC_CNT_W'(1);
  assign x_last     = x_lim - `TC_CNT_W'(1);
  assign y_last     = cfg.tile_s - `TC_CNT_W'(1);

  always_comb begin
    step_d  = step_q;
    inner_d = inner_q;
    x_d     = x_q;
    y_d     = y_q;

    if (step_q == tile_ctrl_pkg::Idle) begin
      if (cfg.start) begin
        step_d = (cfg.layer == tile_ctrl_pkg::Feedforward) ? tile_ctrl_pkg::F1
                                                           : tile_ctrl_pkg::MatMul;
      end
    end else if (tile_done_i) begin
      if (inner_q != inner_last) begin
        inner_d = inner_q + `TC_CNT_W'(1);
      end else begin
        inner_d = '0;
        if (x_q != x_last) begin
          x_d = x_q + `TC_CNT_W'(1);
        end else begin
          x_d = '0;
          if (y_q != y_last) begin
            y_d = y_q + `TC_CNT_W'(1);
          end else begin
            // end of step, counters already cleared
            y_d    = '0;
            step_d = (step_q == tile_ctrl_pkg::F1) ? tile_ctrl_pkg::F2
                                                   : tile_ctrl_pkg::Idle;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q  <= tile_ctrl_pkg::Idle;
      inner_q <= '0;
      x_q     <= '0;
      y_q     <= '0;
    end else begin
      step_q  <= step_d;
      inner_q <= inner_d;
      x_q     <= x_d;
      y_q     <= y_d;
    end
  end

  assign active_o           = (step_q != tile_ctrl_pkg::Idle);
  assign step_o             = step_q;
  assign tile_x_o           = x_q;
  assign tile_y_o           = y_q;
  assign inner_tile_o       = inner_q;
  assign first_inner_tile_o = active_o && (inner_q == '0);
  assign last_inner_tile_o  = active_o && (inner_q == inner_last);
  assign cfg.busy           = active_o;

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the tiling controller testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
  --top-module tb_tile_ctrl -o tb_tile_ctrl \
  && ./obj_dir/tb_tile_ctrl | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
  && echo "simulation run passed" \
  || { echo "simulation run failed"; exit 1; }

// File: sources.f
+incdir+rtl
rtl/tile_ctrl_pkg.sv
rtl/cfg_if.sv
rtl/cfg_regs.sv
rtl/tile_sequencer.sv
rtl/flow_gate.sv
rtl/tile_ctrl_top.sv
verif/tb_tile_ctrl.sv

// File: verif/tb_tile_ctrl.sv
/*
 * testbench for the tiling controller: wishbone tasks, random valids,
 * models of tile indices and output tiles in flight, assertions
 */
`timescale 1ns/1ps
`include "tile_ctrl_macros.svh"

module tb_tile_ctrl;

  localparam int BEATS = `TC_BEATS_PER_TILE;
  localparam int DEPTH = `TC_FIFO_DEPTH;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 wb_cyc_i;
  logic                 wb_stb_i;
  logic                 wb_we_i;
  logic [`TC_WB_AW-1:0] wb_adr_i;
  logic [`TC_WB_DW-1:0] wb_dat_i;
  logic [`TC_WB_DW-1:0] wb_dat_o;
  logic                 wb_ack_o;
  logic                 inp_valid_i = 1'b0;
  logic                 weight_valid_i = 1'b0;
  logic                 bias_valid_i = 1'b0;
  logic                 oup_valid_i;
  logic                 oup_ready_i;
  logic                 inp_ready_o;
  logic                 weight_ready_o;
  logic                 bias_ready_o;
  logic                 calc_en_o;
  tile_ctrl_pkg::step_e step_o;
  logic [`TC_CNT_W-1:0] tile_x_o;
  logic [`TC_CNT_W-1:0] tile_y_o;
  logic [`TC_CNT_W-1:0] inner_tile_o;
  logic                 first_inner_tile_o;
  logic                 last_inner_tile_o;
  logic                 busy_o;

  logic [`TC_CNT_W-1:0]  cfg_s = '0;
  logic [`TC_CNT_W-1:0]  cfg_e = '0;
  logic [`TC_CNT_W-1:0]  cfg_p = '0;
  logic [`TC_CNT_W-1:0]  cfg_f = '0;
  tile_ctrl_pkg::layer_e cfg_layer = tile_ctrl_pkg::Linear;
  tile_ctrl_pkg::step_e  model_step = tile_ctrl_pkg::Idle;
  logic [`TC_CNT_W-1:0]  model_inner = '0;
  logic [`TC_CNT_W-1:0]  model_x = '0;
  logic [`TC_CNT_W-1:0]  model_y = '0;
  int                    model_beat = 0;
  int                    model_inflight = 0;  // output tiles not yet drained
  int                    beat_cnt = 0;
  int                    beats_checked = 0;
  int                    err_cnt = 0;
  logic                  inc;
  logic                  dec;
  logic                  rand_valids = 1'b0;
  logic                  all_valid = 1'b0;
  logic [31:0]           lcg_state = 32'h80be;

  tile_ctrl_top tile_ctrl_top_i (.*);

  always #50 clk_i = ~clk_i;

  // true three times in four
  function automatic logic coin();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23] | lcg_state[29];
  endfunction

  function automatic logic [`TC_CNT_W-1:0] inner_limit(input tile_ctrl_pkg::step_e st);
    return (st == tile_ctrl_pkg::F2) ? cfg_f : cfg_e;
  endfunction

  function automatic logic [`TC_CNT_W-1:0] x_limit(input tile_ctrl_pkg::step_e st);
    case (st)
      tile_ctrl_pkg::F1: return cfg_f;
      tile_ctrl_pkg::F2: return cfg_e;
      default:           return cfg_p;
    endcase
  endfunction

  task automatic value_error(input string name, input int got, input int exp);
    err_cnt++;
    $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
  endtask

  task automatic note_failure(input string what);
    err_cnt++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  task automatic abort_run(input string what);
    err_cnt++;
    $display("Timeout at %0t: %s", $time, what);
    $display("%0d beats checked, %0d errors", beats_checked, err_cnt);
    $display("SOME TESTS FAILED");
    $finish;
  endtask

  // one tile of beats done, step through inner, x, y and the steps
  task automatic advance_model();
    if (model_beat != BEATS - 1) begin
      model_beat++;
    end else begin
      model_beat = 0;
      if (model_inner != inner_limit(model_step) - 8'd1) begin
        model_inner = model_inner + 8'd1;
      end else begin
        model_inner = '0;
        if (model_x != x_limit(model_step) - 8'd1) begin
          model_x = model_x + 8'd1;
        end else begin
          model_x = '0;
          if (model_y != cfg_s - 8'd1) begin
            model_y = model_y + 8'd1;
          end else begin
            model_y    = '0;
            model_step = (model_step == tile_ctrl_pkg::F1) ? tile_ctrl_pkg::F2
                                                           : tile_ctrl_pkg::Idle;
          end
        end
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (rand_valids) begin
      inp_valid_i    <= coin();
      weight_valid_i <= coin();
      bias_valid_i   <= coin();
    end else begin
      inp_valid_i    <= all_valid;
      weight_valid_i <= all_valid;
      bias_valid_i   <= all_valid;
    end
  end

  idle_readies_low: assert property (@(negedge clk_i) disable iff (!rst_ni)
    !busy_o |-> !(inp_ready_o || weight_ready_o || bias_ready_o || calc_en_o))
    else note_failure("a ready or calc_en_o is high while idle");

  ready_follows_valid: assert property (@(negedge clk_i) disable iff (!rst_ni)
    (inp_ready_o || weight_ready_o || bias_ready_o) |->
    (inp_ready_o == weight_valid_i && weight_ready_o == inp_valid_i &&
     bias_ready_o == weight_valid_i))
    else note_failure("readies do not follow the valids");

  // outputs are settled at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (busy_o && model_step == tile_ctrl_pkg::Idle) begin
        model_step  = (cfg_layer == tile_ctrl_pkg::Feedforward) ? tile_ctrl_pkg::F1
                                                                : tile_ctrl_pkg::MatMul;
        model_beat  = 0;
        model_inner = '0;
        model_x     = '0;
        model_y     = '0;
        beat_cnt    = 0;
      end
      assert (step_o == model_step) else value_error("step_o", int'(step_o), int'(model_step));
      if (busy_o && inp_valid_i && weight_valid_i && bias_valid_i && !calc_en_o) begin
        assert (model_inflight == DEPTH)
          else note_failure("calc_en_o low with all valids while the FIFO has room");
      end
      assert (first_inner_tile_o == (busy_o && inner_tile_o == '0))
        else value_error("first_inner_tile_o", int'(first_inner_tile_o), int'(!first_inner_tile_o));
      assert (last_inner_tile_o == (busy_o && inner_tile_o == inner_limit(model_step) - 8'd1))
        else value_error("last_inner_tile_o", int'(last_inner_tile_o), int'(!last_inner_tile_o));
      inc = calc_en_o && (model_inner == inner_limit(model_step) - 8'd1);
      dec = oup_valid_i && oup_ready_i && (model_inflight != 0);
      if (calc_en_o) begin
        assert (inner_tile_o == model_inner)
          else value_error("inner_tile_o", int'(inner_tile_o), int'(model_inner));
        assert (tile_x_o == model_x) else value_error("tile_x_o", int'(tile_x_o), int'(model_x));
        assert (tile_y_o == model_y) else value_error("tile_y_o", int'(tile_y_o), int'(model_y));
        beat_cnt++;
        beats_checked++;
        advance_model();
      end
      if (inc && !dec) model_inflight++;
      if (dec && !inc) model_inflight--;
      assert (model_inflight <= DEPTH)
        else note_failure("more output tiles in flight than the FIFO holds");
    end
  end

  task automatic wb_xfer(input logic we, input logic [`TC_WB_AW-1:0] adr,
                         input logic [`TC_WB_DW-1:0] dat, output logic [`TC_WB_DW-1:0] rdat,
                         output logic bsy);
    int n;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    n = 0;
    @(negedge clk_i);
    while (!wb_ack_o) begin
      if (n == 20) abort_run("no ack on a wishbone transfer");
      n++;
      @(negedge clk_i);
    end
    rdat = wb_dat_o;  // valid with the ack
    bsy  = busy_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input logic [`TC_WB_AW-1:0] adr, input logic [`TC_WB_DW-1:0] dat);
    logic [`TC_WB_DW-1:0] unused_rdat;
    logic unused_bsy;
    wb_xfer(1'b1, adr, dat, unused_rdat, unused_bsy);
  endtask

  task automatic read_expect(input logic [`TC_WB_AW-1:0] adr, input logic [`TC_WB_DW-1:0] exp,
                             input string name);
    logic [`TC_WB_DW-1:0] got;
    logic bsy;
    wb_xfer(1'b0, adr, '0, got, bsy);
    assert (got == exp) else value_error(name, int'(got), int'(exp));
  endtask

  task automatic status_matches_busy();
    logic [`TC_WB_DW-1:0] got;
    logic bsy;
    wb_xfer(1'b0, 3'd5, '0, got, bsy);
    assert (got[0] == bsy) else value_error("STATUS[0]", int'(got[0]), int'(bsy));
  endtask

  task automatic configure(input logic [`TC_CNT_W-1:0] s, input logic [`TC_CNT_W-1:0] e,
                           input logic [`TC_CNT_W-1:0] p, input logic [`TC_CNT_W-1:0] f);
    cfg_s = s;
    cfg_e = e;
    cfg_p = p;
    cfg_f = f;
    wb_write(3'd1, {24'd0, s});
    wb_write(3'd2, {24'd0, e});
    wb_write(3'd3, {24'd0, p});
    wb_write(3'd4, {24'd0, f});
  endtask

  task automatic start_layer(input tile_ctrl_pkg::layer_e layer);
    cfg_layer = layer;
    wb_write(3'd0, {29'd0, layer, 1'b1});
    @(negedge clk_i);
    assert (busy_o) else note_failure("busy_o did not rise after start");
  endtask

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    @(negedge clk_i);
    while (busy_o) begin
      if (n == limit) abort_run("busy_o did not fall");
      n++;
      @(negedge clk_i);
    end
  endtask

  task automatic run_layer(input tile_ctrl_pkg::layer_e layer, input int exp_beats);
    start_layer(layer);
    wait_idle(20000);
    assert (beat_cnt == exp_beats) else value_error("calc_en_o beats", beat_cnt, exp_beats);
  endtask

  initial begin
    logic [`TC_CNT_W-1:0] hold_x;
    logic [`TC_CNT_W-1:0] hold_inner;
    int n;
    rst_ni      <= 1'b0;
    wb_cyc_i    <= 1'b0;
    wb_stb_i    <= 1'b0;
    wb_we_i     <= 1'b0;
    wb_adr_i    <= '0;
    wb_dat_i    <= '0;
    oup_valid_i <= 1'b0;
    oup_ready_i <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    configure(8'd2, 8'd3, 8'd2, 8'd5);
    read_expect(3'd1, 32'd2, "TILE_S");
    read_expect(3'd2, 32'd3, "TILE_E");
    read_expect(3'd3, 32'd2, "TILE_P");
    read_expect(3'd4, 32'd5, "TILE_F");
    wb_write(3'd0, 32'h2);  // feedforward, no start
    read_expect(3'd0, 32'h2, "CTRL");
    status_matches_busy();

    @(posedge clk_i);
    oup_valid_i <= 1'b1;
    oup_ready_i <= 1'b1;
    rand_valids <= 1'b1;
    run_layer(tile_ctrl_pkg::Linear, 2 * 2 * 3 * BEATS);
    configure(8'd2, 8'd2, 8'd1, 8'd3);
    run_layer(tile_ctrl_pkg::Feedforward, 2 * 2 * 2 * 3 * BEATS);

    // one inner tile, every beat produces an output tile
    rand_valids = 1'b0;
    all_valid   = 1'b1;
    @(posedge clk_i);
    oup_valid_i <= 1'b0;
    oup_ready_i <= 1'b0;
    configure(8'd1, 8'd1, 8'd2, 8'd0);
    start_layer(tile_ctrl_pkg::Linear);
    n = 0;
    while (calc_en_o) begin
      if (n == 200) abort_run("calc_en_o never stalled");
      n++;
      @(negedge clk_i);
    end
    assert (beat_cnt == DEPTH) else value_error("beats before stall", beat_cnt, DEPTH);
    hold_x     = tile_x_o;
    hold_inner = inner_tile_o;
    repeat (8) begin
      @(negedge clk_i);
      assert (!calc_en_o) else value_error("calc_en_o", int'(calc_en_o), 0);
      assert (tile_x_o == hold_x) else value_error("tile_x_o", int'(tile_x_o), int'(hold_x));
      assert (inner_tile_o == hold_inner)
        else value_error("inner_tile_o", int'(inner_tile_o), int'(hold_inner));
    end
    status_matches_busy();
    read_expect(3'd0, 32'h0, "CTRL");  // linear, start written as 1
    @(posedge clk_i);
    oup_valid_i <= 1'b1;
    oup_ready_i <= 1'b1;
    wait_idle(2000);
    assert (beat_cnt == 2 * BEATS) else value_error("calc_en_o beats", beat_cnt, 2 * BEATS);
    status_matches_busy();

    $display("%0d beats checked, %0d errors", beats_checked, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
